/* verilog/mc_alu_pkg.sv */
package mc_alu_pkg;

	// ===================================================================
	// Datapath widths and pipeline depth
	// ===================================================================

	// Operand and result width
	localparam int DATA_W = 32;

	// Return tag width, enough for sixteen outstanding requests
	localparam int TAG_W = 4;

	// Register stages inside each arithmetic unit
	localparam int UNIT_STAGES = 3;

	// Accept-to-output depth, the unit stages plus the output register
	localparam int ALU_LATENCY = UNIT_STAGES + 1;

	// ===================================================================
	// IEEE single precision fields and integer saturation values
	// ===================================================================

	localparam int FP_EXP_W = 8;
	localparam int FP_MAN_W = 23;
	localparam int FP_BIAS = 127;

	// Saturation limits of the float to integer conversion
	localparam logic [DATA_W-1:0] INT_MAX = 32'h7FFF_FFFF;
	localparam logic [DATA_W-1:0] INT_MIN = 32'h8000_0000;

	// ===================================================================
	// Opcodes and sideband payload
	// ===================================================================

	// The two product words and the two conversion directions
	typedef enum logic [1:0] {
		OP_MUL_LO = 2'd0,
		OP_MUL_HI = 2'd1,
		OP_I2F    = 2'd2,
		OP_F2I    = 2'd3
	} alu_op_t;

	// Travels beside the units so the result can be picked at the end
	// A bubble is simply an entry whose valid bit is clear
	typedef struct packed {
		logic             valid;
		alu_op_t          op;
		logic [TAG_W-1:0] tag;
	} side_t;

endpackage

/* verilog/pipe_delay.sv */
`timescale 1ns/1ns

module pipe_delay #(
	parameter type T = logic,
	parameter int DEPTH = 1
) (
	input  logic clk,
	input  logic rst_n_i,
	input  logic en_i,
	input  T     d_i,
	output T     q_o
);

	// One register per stage, stage 0 nearest the input
	T stage_q [DEPTH];

	// Shift the whole chain only on enabled edges so a stalled pipeline
	// keeps every entry where it is
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			// Clearing to zero also clears any valid bit inside the payload
			for (int i = 0; i < DEPTH; i++) begin
				stage_q[i] <= '0;
			end
		end else if (en_i) begin
			stage_q[0] <= d_i;
			for (int i = 1; i < DEPTH; i++) begin
				stage_q[i] <= stage_q[i-1];
			end
		end
	end

	// The oldest entry leaves at the far end
	assign q_o = stage_q[DEPTH-1];

endmodule

/* verilog/int_mul_pipe.sv */
`timescale 1ns/1ns

module int_mul_pipe (
	input  logic                             clk,
	input  logic                             rst_n_i,
	input  logic                             en_i,
	input  logic [mc_alu_pkg::DATA_W-1:0]    a_i,
	input  logic [mc_alu_pkg::DATA_W-1:0]    b_i,
	output logic [2*mc_alu_pkg::DATA_W-1:0]  prod_o
);

	import mc_alu_pkg::*;

	// Operand halves
	logic [DATA_W/2-1:0] a_lo;
	logic [DATA_W/2-1:0] a_hi;
	logic [DATA_W/2-1:0] b_lo;
	logic [DATA_W/2-1:0] b_hi;

	// Stage one, the four 16x16 partial products
	logic [DATA_W-1:0] pp_ll_q;
	logic [DATA_W-1:0] pp_lh_q;
	logic [DATA_W-1:0] pp_hl_q;
	logic [DATA_W-1:0] pp_hh_q;

	// Stage two, the cross sum keeps its carry and the outer terms sit side by side
	logic [DATA_W:0]     cross_q;
	logic [2*DATA_W-1:0] outer_q;

	// Stage three input, the full product before its register
	logic [2*DATA_W-1:0] sum_d;

	// Tracks how many enabled edges have passed since reset
	logic [UNIT_STAGES-1:0] fill_q;

	assign a_lo = a_i[DATA_W/2-1:0];
	assign a_hi = a_i[DATA_W-1:DATA_W/2];
	assign b_lo = b_i[DATA_W/2-1:0];
	assign b_hi = b_i[DATA_W-1:DATA_W/2];

	always_ff @(posedge clk) begin
		if (en_i) begin
			pp_ll_q <= a_lo * b_lo;
			pp_lh_q <= a_lo * b_hi;
			pp_hl_q <= a_hi * b_lo;
			pp_hh_q <= a_hi * b_hi;
			cross_q <= pp_lh_q + pp_hl_q;
			outer_q <= {pp_hh_q, pp_ll_q};
		end
	end

	// Cross terms carry a weight of 2^16
	assign sum_d = outer_q + {{(DATA_W/2-1){1'b0}}, cross_q, {(DATA_W/2){1'b0}}};

	pipe_delay #(
		.T     (logic [2*DATA_W-1:0]),
		.DEPTH (1)
	) u_sum_stage (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.en_i    (en_i),
		.d_i     (sum_d),
		.q_o     (prod_o)
	);

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			fill_q <= '0;
		end else if (en_i) begin
			fill_q <= {fill_q[UNIT_STAGES-2:0], 1'b1};
		end
	end

	// Once an operand pair has walked all three stages the product is known
	a_prod_known: assert property (@(posedge clk) disable iff (!rst_n_i)
		fill_q[UNIT_STAGES-1] |-> !$isunknown(prod_o));

endmodule

/* verilog/fp_convert_pipe.sv */
`timescale 1ns/1ns

module fp_convert_pipe (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          en_i,
	input  logic [mc_alu_pkg::DATA_W-1:0] a_i,
	output logic [mc_alu_pkg::DATA_W-1:0] i2f_o,
	output logic [mc_alu_pkg::DATA_W-1:0] f2i_o
);

	import mc_alu_pkg::*;

	// ===================================================================
	// Integer to float path
	// ===================================================================

	logic                s1_sign_q;
	logic [DATA_W-1:0]   s1_mag_q;
	logic [4:0]          lz;
	logic                s2_sign_q;
	logic                s2_zero_q;
	logic [FP_EXP_W-1:0] s2_exp_q;
	logic [DATA_W-1:0]   s2_norm_q;
	logic                round_up;
	logic [FP_EXP_W+FP_MAN_W-1:0] packed_d;
	logic [DATA_W-1:0]   i2f_q;

	// Leading zero count, a zero input is flagged separately
	function automatic logic [4:0] lead_zeros(input logic [DATA_W-1:0] v);
		logic [4:0] n;
		n = '0;
		for (int i = 0; i < DATA_W; i++) begin
			if (v[i]) begin
				n = 5'(DATA_W - 1 - i);
			end
		end
		return n;
	endfunction

	assign lz = lead_zeros(s1_mag_q);

	// Round to nearest even on the bits below the 23-bit mantissa
	// A mantissa overflow carries straight into the exponent field
	assign round_up = s2_norm_q[DATA_W-FP_MAN_W-2]
		& (s2_norm_q[DATA_W-FP_MAN_W-1] | (|s2_norm_q[DATA_W-FP_MAN_W-3:0]));
	assign packed_d = {s2_exp_q, s2_norm_q[DATA_W-2 -: FP_MAN_W]}
		+ (FP_EXP_W+FP_MAN_W)'(round_up);

	always_ff @(posedge clk) begin
		if (en_i) begin
			// Negating 80000000 gives back 2^31 as an unsigned magnitude
			s1_sign_q <= a_i[DATA_W-1];
			s1_mag_q  <= a_i[DATA_W-1] ? -a_i : a_i;
			s2_sign_q <= s1_sign_q;
			s2_zero_q <= (s1_mag_q == '0);
			s2_exp_q  <= FP_EXP_W'(FP_BIAS + DATA_W - 1) - FP_EXP_W'(lz);
			s2_norm_q <= s1_mag_q << lz;
			i2f_q     <= s2_zero_q ? '0 : {s2_sign_q, packed_d};
		end
	end

	// ===================================================================
	// Float to integer path
	// ===================================================================

	logic                u1_sign_q;
	logic [FP_EXP_W-1:0] u1_exp_q;
	logic [FP_MAN_W:0]   u1_man_q;
	logic                u1_nan_q;
	logic [4:0]          shift_amt;
	logic                u2_sign_q;
	logic                u2_sat_q;
	logic                u2_nan_q;
	logic [DATA_W-1:0]   u2_mag_q;
	logic [DATA_W-1:0]   f2i_q;

	// With the hidden bit at the top of a word, 2^30 needs a shift of one
	assign shift_amt = 5'(FP_BIAS + DATA_W - 1 - int'(u1_exp_q));

	always_ff @(posedge clk) begin
		if (en_i) begin
			u1_sign_q <= a_i[DATA_W-1];
			u1_exp_q  <= a_i[DATA_W-2 -: FP_EXP_W];
			u1_man_q  <= {|a_i[DATA_W-2 -: FP_EXP_W], a_i[FP_MAN_W-1:0]};
			u1_nan_q  <= (&a_i[DATA_W-2 -: FP_EXP_W]) && (|a_i[FP_MAN_W-1:0]);
			u2_sign_q <= u1_sign_q;
			u2_nan_q  <= u1_nan_q;
			// Infinity falls in here as well
			u2_sat_q  <= int'(u1_exp_q) >= FP_BIAS + DATA_W - 1;
			// Values below one truncate to zero
			if (int'(u1_exp_q) < FP_BIAS) begin
				u2_mag_q <= '0;
			end else begin
				u2_mag_q <= {u1_man_q, {(DATA_W-FP_MAN_W-1){1'b0}}} >> shift_amt;
			end
			if (u2_nan_q) begin
				f2i_q <= INT_MAX;
			end else if (u2_sat_q) begin
				f2i_q <= u2_sign_q ? INT_MIN : INT_MAX;
			end else begin
				f2i_q <= u2_sign_q ? -u2_mag_q : u2_mag_q;
			end
		end
	end

	assign i2f_o = i2f_q;
	assign f2i_o = f2i_q;

	// Track the pipeline fill so the check below starts on real data
	logic [UNIT_STAGES-1:0] fill_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			fill_q <= '0;
		end else if (en_i) begin
			fill_q <= {fill_q[UNIT_STAGES-2:0], 1'b1};
		end
	end

	// Apart from zero, normalization leaves the leading one in the top bit
	a_i2f_normalized: assert property (@(posedge clk) disable iff (!rst_n_i)
		fill_q[UNIT_STAGES-1] |-> s2_zero_q || s2_norm_q[DATA_W-1]);

endmodule

/* verilog/mc_alu_result_stage.sv */
`timescale 1ns/1ns

module mc_alu_result_stage (
	input  logic                            clk,
	input  logic                            rst_n_i,
	input  logic                            in_valid_i,
	input  mc_alu_pkg::alu_op_t             in_op_i,
	input  logic [mc_alu_pkg::TAG_W-1:0]    in_tag_i,
	input  logic [2*mc_alu_pkg::DATA_W-1:0] prod_i,
	input  logic [mc_alu_pkg::DATA_W-1:0]   i2f_i,
	input  logic [mc_alu_pkg::DATA_W-1:0]   f2i_i,
	input  logic                            out_ready_i,
	output logic                            advance_o,
	output logic                            out_valid_o,
	output logic [mc_alu_pkg::DATA_W-1:0]   out_result_o,
	output logic [mc_alu_pkg::TAG_W-1:0]    out_tag_o
);

	import mc_alu_pkg::*;

	side_t             side_d;
	side_t             side_q;
	logic [DATA_W-1:0] result_d;
	logic              out_valid_q;
	logic [DATA_W-1:0] result_q;
	logic [TAG_W-1:0]  tag_q;

	// The whole pipeline moves when the output slot is free or being emptied
	assign advance_o = !out_valid_q || out_ready_i;

	assign side_d = '{valid: in_valid_i, op: in_op_i, tag: in_tag_i};

	// Same depth as the units, so opcode and tag meet their own result
	pipe_delay #(
		.T     (side_t),
		.DEPTH (UNIT_STAGES)
	) u_side_delay (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.en_i    (advance_o),
		.d_i     (side_d),
		.q_o     (side_q)
	);

	always_comb begin
		case (side_q.op)
			OP_MUL_LO: result_d = prod_i[DATA_W-1:0];
			OP_MUL_HI: result_d = prod_i[2*DATA_W-1:DATA_W];
			OP_I2F:    result_d = i2f_i;
			OP_F2I:    result_d = f2i_i;
			default:   result_d = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			out_valid_q <= 1'b0;
		end else if (advance_o) begin
			out_valid_q <= side_q.valid;
		end
	end

	always_ff @(posedge clk) begin
		if (advance_o) begin
			result_q <= result_d;
			tag_q    <= side_q.tag;
		end
	end

	assign out_valid_o  = out_valid_q;
	assign out_result_o = result_q;
	assign out_tag_o    = tag_q;

	// A held output keeps its item until the consumer takes it
	a_out_hold: assert property (@(posedge clk) disable iff (!rst_n_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o)
			&& $stable(out_tag_o));

	// A stall freezes the sideband line along with the units
	a_side_frozen: assert property (@(posedge clk) disable iff (!rst_n_i)
		!advance_o |=> $stable(side_q));

endmodule

/* verilog/mc_alu_top.sv */
`timescale 1ns/1ns

module mc_alu_top (
	input  logic                          clk,
	input  logic                          rst_n_i,
	input  logic                          in_valid_i,
	output logic                          in_ready_o,
	input  mc_alu_pkg::alu_op_t           in_op_i,
	input  logic [mc_alu_pkg::DATA_W-1:0] in_a_i,
	input  logic [mc_alu_pkg::DATA_W-1:0] in_b_i,
	input  logic [mc_alu_pkg::TAG_W-1:0]  in_tag_i,
	output logic                          out_valid_o,
	input  logic                          out_ready_i,
	output logic [mc_alu_pkg::DATA_W-1:0] out_result_o,
	output logic [mc_alu_pkg::TAG_W-1:0]  out_tag_o
);

	import mc_alu_pkg::*;

	// Global enable from the result stage, shared by every pipeline stage
	logic                advance;
	logic [2*DATA_W-1:0] prod;
	logic [DATA_W-1:0]   i2f;
	logic [DATA_W-1:0]   f2i;

	// Input is accepted exactly when the pipeline moves
	assign in_ready_o = advance;

	// Both units see every operand pair, the opcode only matters at the end
	int_mul_pipe u_int_mul (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.en_i    (advance),
		.a_i     (in_a_i),
		.b_i     (in_b_i),
		.prod_o  (prod)
	);

	// Conversions take operand a only
	fp_convert_pipe u_fp_convert (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.en_i    (advance),
		.a_i     (in_a_i),
		.i2f_o   (i2f),
		.f2i_o   (f2i)
	);

	mc_alu_result_stage u_result (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.in_valid_i   (in_valid_i),
		.in_op_i      (in_op_i),
		.in_tag_i     (in_tag_i),
		.prod_i       (prod),
		.i2f_i        (i2f),
		.f2i_i        (f2i),
		.out_ready_i  (out_ready_i),
		.advance_o    (advance),
		.out_valid_o  (out_valid_o),
		.out_result_o (out_result_o),
		.out_tag_o    (out_tag_o)
	);

endmodule

/* verification/mc_alu_vectors.svh */
`ifndef MC_ALU_VECTORS_SVH
`define MC_ALU_VECTORS_SVH

// Columns are opcode, operand a, operand b and the expected result
typedef struct packed {
	alu_op_t     op;
	logic [31:0] a;
	logic [31:0] b;
	logic [31:0] result;
} vector_t;

localparam int NUM_VECS = 22;

localparam vector_t VECTORS [NUM_VECS] = '{
	// Unsigned 64-bit products, split into low and high words
	'{OP_MUL_LO, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000},
	'{OP_MUL_HI, 32'h0000_0000, 32'h1234_5678, 32'h0000_0000},
	'{OP_MUL_LO, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'h0000_0001},
	'{OP_MUL_HI, 32'hFFFF_FFFF, 32'hFFFF_FFFF, 32'hFFFF_FFFE},
	// (2^17 - 1) squared carries out of the low 16-bit half
	'{OP_MUL_LO, 32'h0001_FFFF, 32'h0001_FFFF, 32'hFFFC_0001},
	'{OP_MUL_HI, 32'h0001_FFFF, 32'h0001_FFFF, 32'h0000_0003},
	'{OP_MUL_LO, 32'hFFFF_0000, 32'h0000_FFFF, 32'h0001_0000},
	'{OP_MUL_HI, 32'hFFFF_0000, 32'h0000_FFFF, 32'h0000_FFFE},
	// Signed integer to single, 2^24+1 ties down to even and 2^24+3 ties up
	'{OP_I2F,    32'h0000_0000, 32'h0000_0000, 32'h0000_0000},
	'{OP_I2F,    32'h0000_0001, 32'h0000_0000, 32'h3F80_0000},
	'{OP_I2F,    32'hFFFF_FFFF, 32'h0000_0000, 32'hBF80_0000},
	'{OP_I2F,    32'h0100_0001, 32'h0000_0000, 32'h4B80_0000},
	'{OP_I2F,    32'h0100_0003, 32'h0000_0000, 32'h4B80_0002},
	'{OP_I2F,    32'h7FFF_FFFF, 32'h0000_0000, 32'h4F00_0000},
	'{OP_I2F,    32'h8000_0000, 32'h0000_0000, 32'hCF00_0000},
	// Single to signed integer: 1.5, -2.75, 0.25, 3e9, -3e9, NaN, -2^31
	'{OP_F2I,    32'h3FC0_0000, 32'h0000_0000, 32'h0000_0001},
	'{OP_F2I,    32'hC030_0000, 32'h0000_0000, 32'hFFFF_FFFE},
	'{OP_F2I,    32'h3E80_0000, 32'h0000_0000, 32'h0000_0000},
	'{OP_F2I,    32'h4F32_D05E, 32'h0000_0000, 32'h7FFF_FFFF},
	'{OP_F2I,    32'hCF32_D05E, 32'h0000_0000, 32'h8000_0000},
	'{OP_F2I,    32'h7FC0_0000, 32'h0000_0000, 32'h7FFF_FFFF},
	'{OP_F2I,    32'hCF00_0000, 32'h0000_0000, 32'h8000_0000}
};

`endif

/* verification/mc_alu_tb.sv */
`timescale 1ns/1ns

module mc_alu_tb;

	import mc_alu_pkg::*;

	`include "mc_alu_vectors.svh"

	// Longest any single wait loop may run, in clock cycles
	localparam int WAIT_LIMIT = 2000;
	localparam logic [31:0] SEED = 32'h4ea7_a214;

	logic                clk = 1'b0;
	logic                rst_n_i;
	logic                in_valid_i;
	logic                in_ready_o;
	alu_op_t             in_op_i;
	logic [DATA_W-1:0]   in_a_i;
	logic [DATA_W-1:0]   in_b_i;
	logic [TAG_W-1:0]    in_tag_i;
	logic                out_valid_o;
	logic                out_ready_i;
	logic [DATA_W-1:0]   out_result_o;
	logic [TAG_W-1:0]    out_tag_o;

	// Table indices of accepted items, oldest first
	int    exp_q [$];
	// Edge numbers of output transfers
	int    rx_edges [$];
	int    edge_cnt = 0;
	int    rx_count = 0;
	int    accept_edge;
	int    waited;
	int    burst_start;
	logic  random_ready;
	string cur_test = "reset";

	mc_alu_top u_mc_alu_top (
		.clk          (clk),
		.rst_n_i      (rst_n_i),
		.in_valid_i   (in_valid_i),
		.in_ready_o   (in_ready_o),
		.in_op_i      (in_op_i),
		.in_a_i       (in_a_i),
		.in_b_i       (in_b_i),
		.in_tag_i     (in_tag_i),
		.out_valid_o  (out_valid_o),
		.out_ready_i  (out_ready_i),
		.out_result_o (out_result_o),
		.out_tag_o    (out_tag_o)
	);

	initial begin
		forever #5 clk = ~clk;
	end

	always @(posedge clk) begin
		edge_cnt <= edge_cnt + 1;
	end

	// ===================================================================
	// Failure reporting
	// ===================================================================

	task automatic report_mismatch(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("[ERROR] %s expected %08h actual %08h", name, expected, actual);
		$display("tests failed");
		$fatal(1, "value mismatch");
	endtask

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("tests failed");
		$fatal(1, "stopped at first error");
	endtask

	function automatic string vector_name(input int idx);
		alu_op_t op;
		op = VECTORS[idx].op;
		return $sformatf("%s %s #%0d", cur_test, op.name(), idx);
	endfunction

	// ===================================================================
	// Output monitor, sampled at the falling edge where all is stable
	// ===================================================================

	always @(negedge clk) begin : output_monitor
		int idx;
		if (!rst_n_i) begin
			assert (!out_valid_o) else fail_now("out_valid_o was high during reset");
		end else begin
			// A held output must stall the input side too
			if (out_valid_o && !out_ready_i) begin
				assert (!in_ready_o) else fail_now("in_ready_o high while the output was held");
			end
			// Both high here means the item transfers on the coming edge
			if (out_valid_o && out_ready_i) begin
				assert (exp_q.size() > 0)
					else fail_now("a result appeared with no request outstanding");
				idx = exp_q.pop_front();
				assert (out_result_o === VECTORS[idx].result)
					else report_mismatch(vector_name(idx), VECTORS[idx].result, out_result_o);
				assert (out_tag_o === TAG_W'(idx % 16))
					else report_mismatch({vector_name(idx), " tag"}, idx % 16, 32'(out_tag_o));
				rx_edges.push_back(edge_cnt);
				rx_count++;
			end
		end
	end

	// Random back-pressure, changed just after each rising edge
	always @(posedge clk) begin
		#1;
		if (random_ready) begin
			out_ready_i = 1'($urandom % 2);
		end
	end

	// ===================================================================
	// Stimulus tasks, all entered and left 1 ns after a rising edge
	// ===================================================================

	task automatic send_item(input int idx, output int accepted_on);
		int count;
		count = 0;
		in_valid_i = 1'b1;
		in_op_i    = VECTORS[idx].op;
		in_a_i     = VECTORS[idx].a;
		in_b_i     = VECTORS[idx].b;
		in_tag_i   = TAG_W'(idx % 16);
		@(negedge clk);
		while (!in_ready_o) begin
			count++;
			assert (count <= WAIT_LIMIT) else fail_now("the DUT never accepted an input");
			@(negedge clk);
		end
		// The transfer happens on the next rising edge
		accepted_on = edge_cnt + 1;
		exp_q.push_back(idx);
		@(posedge clk);
		#1;
	endtask

	task automatic go_idle();
		in_valid_i = 1'b0;
	endtask

	task automatic run_table();
		int acc;
		for (int i = 0; i < NUM_VECS; i++) begin
			send_item(i, acc);
		end
		go_idle();
	endtask

	task automatic wait_drained();
		int count;
		count = 0;
		while (exp_q.size() != 0) begin
			count++;
			assert (count <= WAIT_LIMIT) else fail_now("outstanding results never arrived");
			@(negedge clk);
		end
		@(posedge clk);
		#1;
	endtask

	// ===================================================================
	// Test sequence
	// ===================================================================

	initial begin
		void'($urandom(SEED));
		rst_n_i      = 1'b0;
		in_valid_i   = 1'b0;
		in_op_i      = OP_MUL_LO;
		in_a_i       = '0;
		in_b_i       = '0;
		in_tag_i     = '0;
		out_ready_i  = 1'b1;
		random_ready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n_i = 1'b1;

		// Nothing may come out before the first input is accepted
		repeat (ALU_LATENCY + 2) begin
			@(negedge clk);
			assert (!out_valid_o) else fail_now("a stale result appeared after reset");
		end
		@(posedge clk);
		#1;

		// Single item through an empty pipeline
		cur_test = "latency";
		send_item(0, accept_edge);
		go_idle();
		waited = 0;
		@(negedge clk);
		while (!out_valid_o) begin
			waited++;
			assert (waited <= WAIT_LIMIT) else fail_now("the single item never came out");
			@(negedge clk);
		end
		// The item leaves on the coming edge, counted like the accept edge
		assert (edge_cnt + 1 - accept_edge == ALU_LATENCY)
			else report_mismatch("latency", ALU_LATENCY, edge_cnt + 1 - accept_edge);
		wait_drained();

		// Whole table back to back, results must leave one per cycle
		cur_test = "table";
		burst_start = rx_count;
		run_table();
		wait_drained();
		assert (rx_edges[burst_start + NUM_VECS - 1] - rx_edges[burst_start] == NUM_VECS - 1)
			else report_mismatch("table burst spacing", NUM_VECS - 1,
				rx_edges[burst_start + NUM_VECS - 1] - rx_edges[burst_start]);

		// Same table under random output stalls
		cur_test = "backpressure";
		random_ready = 1'b1;
		run_table();
		wait_drained();
		random_ready = 1'b0;
		out_ready_i  = 1'b1;

		// Any extra output in this quiet stretch trips the monitor
		repeat (ALU_LATENCY + 2) @(posedge clk);
		#1;

		$display("all tests passed");
		$finish;
	end

endmodule

/* mc_alu.f */
+incdir+verification
verilog/mc_alu_pkg.sv
verilog/pipe_delay.sv
verilog/int_mul_pipe.sv
verilog/fp_convert_pipe.sv
verilog/mc_alu_result_stage.sv
verilog/mc_alu_top.sv
verification/mc_alu_tb.sv

/* Makefile */
# Verilator build and run for the multicycle ALU testbench

VERILATOR ?= verilator
TOP       ?= mc_alu_tb
FILELIST  ?= mc_alu.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM       ?= $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# The simulator exits with a failing status on $fatal
run: compile
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
